// ==== cdi_host_glue.f ====
hw/cdi_host_pkg.sv
hw/cdi_mem_pkg.sv
hw/slave_worm_loader.sv
hw/boot_sdram_arbiter.sv
hw/nvram_sync_fsm.sv
hw/cdi_host_glue.sv
testbench/cdi_host_glue_chk.sv
testbench/tb_cdi_host_glue.sv

// ==== hw/boot_sdram_arbiter.sv ====
module boot_sdram_arbiter (
    input  logic                    clk_sys,
    input  logic                    cditop_reset,
    input  cdi_host_pkg::ioctl_s    ioctl,
    input  cdi_mem_pkg::sdram_req_s core_req,
    input  logic                    sdram_busy,
    output cdi_mem_pkg::sdram_req_s sdram_req,
    output logic                    download_overflow
);
    import cdi_host_pkg::*;
    import cdi_mem_pkg::*;

    typedef enum logic [1:0] {
        rom_download,
        refresh,
        idle
    } owner_t;

    rom_sel_t                sel;
    logic                    rom_strobe;
    logic                    pending;
    logic                    busy_q;
    logic                    download_q;
    logic                    done;
    owner_t                  owner;
    owner_t                  owner_q;
    sdram_req_s              own_req;
    logic [sdram_addr_w-1:0] dl_addr;
    logic [sdram_data_w-1:0] dl_data;

    assign sel        = index_sel(ioctl.index);
    assign rom_strobe = ioctl.wr && (sel == main_rom || sel == vmpeg_rom);

    // Falling busy after our own accepted write
    assign done = (owner_q == rom_download) && busy_q && !sdram_busy;

    // ==================================================================
    // Owner selection and request
    // ==================================================================

    always_comb begin
        owner = idle;
        if (cditop_reset) begin
            owner = (pending && !done) ? rom_download : refresh;
        end
    end

    always_comb begin
        own_req      = '0;
        own_req.word = 1'b1;
        case (owner)
            rom_download: begin
                own_req.addr = dl_addr;
                own_req.data = dl_data;
                own_req.wr   = 1'b1;
            end
            refresh: begin
                own_req.rd      = 1'b1;
                own_req.refresh = 1'b1;
            end
            default: begin
            end
        endcase
        // Controller only takes requests while not busy
        if (sdram_busy) begin
            own_req.rd = 1'b0;
            own_req.wr = 1'b0;
        end
    end

    // Core has SDRAM to itself once out of reset
    assign sdram_req = cditop_reset ? own_req : core_req;

    // ==================================================================
    // Pending latch and overflow
    // ==================================================================

    always_ff @(posedge clk_sys) begin
        download_q <= ioctl.download;
        busy_q     <= sdram_busy;

        if (!ioctl.download && !sdram_busy) begin
            // No download running and the last write has gone out
            pending <= 1'b0;
            owner_q <= idle;
        end else begin
            if (!sdram_busy) begin
                owner_q <= owner;
            end
            if (rom_strobe) begin
                pending <= 1'b1;
            end else if (done) begin
                pending <= 1'b0;
            end
        end

        // Sticky until the next download starts
        if (ioctl.download && !download_q) begin
            download_overflow <= 1'b0;
        end else if (rom_strobe && pending && !done) begin
            download_overflow <= 1'b1;
        end
    end

    // Word is mapped into the ROM area and swapped to big endian
    always_ff @(posedge clk_sys) begin
        if (rom_strobe && (!pending || done)) begin
            dl_addr <= {rom_region_hi, ioctl.index[7], ioctl.addr[18:1], 1'b0};
            dl_data <= {ioctl.dout[7:0], ioctl.dout[15:8]};
        end
    end

endmodule

// ==== hw/cdi_host_glue.sv ====
module cdi_host_glue (
    input  logic                      clk_sys,
    input  logic                      cditop_reset,

    // Download from the host
    input  cdi_host_pkg::ioctl_s      ioctl,

    // SDRAM
    input  cdi_mem_pkg::sdram_req_s   core_req,
    input  logic                      sdram_busy,
    output cdi_mem_pkg::sdram_req_s   sdram_req,
    output logic                      download_overflow,

    // Slave WORM
    output cdi_mem_pkg::worm_wr_s     worm_wr,

    // NvRAM image and backup port
    input  cdi_host_pkg::blk_buf_s    nvram_blk,
    input  logic                      nvram_mount,
    input  logic                      osd_status,
    input  logic                      nvram_cpu_changed,
    input  logic [7:0]                nvram_backup_data,
    output cdi_mem_pkg::nvram_port_s  nvram_port,
    output logic                      nvram_hps_rd,
    output logic                      nvram_hps_wr,
    output cdi_host_pkg::host_word_t  nvram_hps_din,
    output logic                      nvram_allow_cpu_access,
    output logic                      backup_pending
);

    // Slave microcontroller firmware
    slave_worm_loader u_worm_loader (
        .clk_sys      (clk_sys),
        .cditop_reset (cditop_reset),
        .ioctl        (ioctl),
        .worm_wr      (worm_wr)
    );

    // Boot and MPEG ROMs plus SDRAM ownership during reset
    boot_sdram_arbiter u_sdram_arbiter (
        .clk_sys           (clk_sys),
        .cditop_reset      (cditop_reset),
        .ioctl             (ioctl),
        .core_req          (core_req),
        .sdram_busy        (sdram_busy),
        .sdram_req         (sdram_req),
        .download_overflow (download_overflow)
    );

    // NvRAM restore from and backup to the mounted image
    nvram_sync_fsm u_nvram_sync (
        .clk_sys                (clk_sys),
        .cditop_reset           (cditop_reset),
        .nvram_blk              (nvram_blk),
        .nvram_mount            (nvram_mount),
        .osd_status             (osd_status),
        .nvram_cpu_changed      (nvram_cpu_changed),
        .nvram_backup_data      (nvram_backup_data),
        .nvram_port             (nvram_port),
        .nvram_hps_rd           (nvram_hps_rd),
        .nvram_hps_wr           (nvram_hps_wr),
        .nvram_hps_din          (nvram_hps_din),
        .nvram_allow_cpu_access (nvram_allow_cpu_access),
        .backup_pending         (backup_pending)
    );

endmodule

// ==== hw/cdi_host_pkg.sv ====
package cdi_host_pkg;

    // ==================================================================
    // Host protocol widths
    // ==================================================================

    localparam int ioctl_addr_w = 25;

    // Slave write-once memory is 8 KB
    localparam int worm_addr_w = 13;

    // Host words arrive little-endian
    typedef logic [15:0] host_word_t;

    // ==================================================================
    // Download transfers
    // ==================================================================

    typedef struct packed {
        logic                    download;
        logic                    wr;
        logic [ioctl_addr_w-1:0] addr;
        host_word_t              dout;
        logic [15:0]             index;
    } ioctl_s;

    // Target of a download, taken from index bits 7:6
    typedef enum logic [1:0] {
        main_rom   = 2'b00,
        slave_worm = 2'b01,
        vmpeg_rom  = 2'b10
    } rom_sel_t;

    function automatic rom_sel_t index_sel(input logic [15:0] index);
        return rom_sel_t'(index[7:6]);
    endfunction

    // ==================================================================
    // Image block buffer
    // ==================================================================

    typedef struct packed {
        logic       ack;
        logic       buff_wr;
        logic [7:0] buff_addr;
        host_word_t buff_dout;
    } blk_buf_s;

    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } byte_pair_s;

    // One NvRAM word seen whole or as its two bytes
    typedef union packed {
        host_word_t word;
        byte_pair_s bytes;
    } nvram_word_u;

endpackage

// ==== hw/cdi_mem_pkg.sv ====
package cdi_mem_pkg;

    // ==================================================================
    // SDRAM side
    // ==================================================================

    localparam int sdram_addr_w = 25;
    localparam int sdram_data_w = 16;

    // Upper address bits of the ROM area
    localparam logic [4:0] rom_region_hi = 5'b00100;

    // One request towards the SDRAM controller
    typedef struct packed {
        logic [sdram_addr_w-1:0] addr;
        logic [sdram_data_w-1:0] data;
        logic                    rd;
        logic                    wr;
        logic                    word;
        logic                    refresh;
        logic                    burst;
    } sdram_req_s;

    // ==================================================================
    // NvRAM side
    // ==================================================================

    // Byte address into the 8 KB NvRAM
    localparam int nvram_addr_w = 13;

    // Backup and restore port of the NvRAM
    typedef struct packed {
        logic [nvram_addr_w-1:0] addr;
        logic [7:0]              restore_data;
        logic                    restore_write;
    } nvram_port_s;

    // ==================================================================
    // Slave write-once memory
    // ==================================================================

    // Byte write into the slave microcontroller's WORM
    typedef struct packed {
        logic [cdi_host_pkg::worm_addr_w-1:0] addr;
        logic [7:0]                           data;
        logic                                 wr;
    } worm_wr_s;

endpackage

// ==== hw/nvram_sync_fsm.sv ====
module nvram_sync_fsm (
    input  logic                     clk_sys,
    input  logic                     cditop_reset,
    input  cdi_host_pkg::blk_buf_s   nvram_blk,
    input  logic                     nvram_mount,
    input  logic                     osd_status,
    input  logic                     nvram_cpu_changed,
    input  logic [7:0]               nvram_backup_data,
    output cdi_mem_pkg::nvram_port_s nvram_port,
    output logic                     nvram_hps_rd,
    output logic                     nvram_hps_wr,
    output cdi_host_pkg::host_word_t nvram_hps_din,
    output logic                     nvram_allow_cpu_access,
    output logic                     backup_pending
);
    import cdi_host_pkg::*;
    import cdi_mem_pkg::*;

    typedef enum logic [3:0] {
        idle,
        wait_ack,
        backup0,
        backup1,
        backup2,
        backup3,
        restore0,
        restore1,
        restore2
    } state_t;

    state_t                  state;
    logic                    osd_q;
    logic                    buff_addr0_q;
    logic                    osd_rise;
    logic                    buff_step;
    logic                    restore_write;
    logic [nvram_addr_w-1:0] addr;
    nvram_word_u             restore_word;
    nvram_word_u             backup_word;

    assign osd_rise  = osd_status && !osd_q;
    // Host moved on to the next buffer word
    assign buff_step = buff_addr0_q != nvram_blk.buff_addr[0];

    // ==================================================================
    // Control
    // ==================================================================

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            state                  <= idle;
            osd_q                  <= 1'b0;
            buff_addr0_q           <= 1'b0;
            nvram_hps_rd           <= 1'b0;
            nvram_hps_wr           <= 1'b0;
            restore_write          <= 1'b0;
            backup_pending         <= 1'b0;
            nvram_allow_cpu_access <= 1'b1;
        end else begin
            osd_q         <= osd_status;
            buff_addr0_q  <= nvram_blk.buff_addr[0];
            restore_write <= 1'b0;

            if (nvram_cpu_changed) begin
                backup_pending <= 1'b1;
            end

            // Requests drop once the host acknowledges
            if (nvram_blk.ack) begin
                nvram_hps_rd <= 1'b0;
                nvram_hps_wr <= 1'b0;
            end

            case (state)
                idle: begin
                    nvram_allow_cpu_access <= 1'b1;
                    if (nvram_mount) begin
                        nvram_hps_rd           <= 1'b1;
                        nvram_allow_cpu_access <= 1'b0;
                        state                  <= wait_ack;
                    end else if (backup_pending && osd_rise) begin
                        // Later CPU changes will ask for another backup
                        backup_pending         <= 1'b0;
                        nvram_hps_wr           <= 1'b1;
                        nvram_allow_cpu_access <= 1'b0;
                        state                  <= wait_ack;
                    end
                end
                wait_ack: begin
                    if (nvram_blk.ack && nvram_hps_rd) begin
                        state <= restore0;
                    end else if (nvram_blk.ack && nvram_hps_wr) begin
                        state <= backup0;
                    end
                end
                backup0: state <= backup1;
                backup1: state <= backup2;
                backup2: state <= backup3;
                backup3: begin
                    if (buff_step) begin
                        state <= backup1;
                    end
                    if (!nvram_blk.ack) begin
                        state <= idle;
                    end
                end
                restore0: begin
                    if (nvram_blk.buff_wr) begin
                        restore_write <= 1'b1;
                        state         <= restore1;
                    end
                    if (!nvram_blk.ack) begin
                        nvram_allow_cpu_access <= 1'b1;
                        state                  <= idle;
                    end
                end
                restore1: begin
                    restore_write <= 1'b1;
                    state         <= restore2;
                end
                restore2: state <= restore0;
                default:  state <= idle;
            endcase
        end
    end

    // ==================================================================
    // Address and data path
    // ==================================================================

    always_ff @(posedge clk_sys) begin
        case (state)
            idle: addr <= '0;
            backup0: addr <= addr + 1'b1;
            backup1: begin
                // Byte read data lags the address by one cycle
                backup_word.bytes.lo <= nvram_backup_data;
                addr                 <= addr + 1'b1;
            end
            backup2: backup_word.bytes.hi <= nvram_backup_data;
            backup3: begin
                if (buff_step) begin
                    addr <= addr + 1'b1;
                end
            end
            restore0: begin
                if (nvram_blk.buff_wr) begin
                    restore_word.word <= nvram_blk.buff_dout;
                end
            end
            restore1: addr <= addr + 1'b1;
            restore2: addr <= addr + 1'b1;
            default: begin
            end
        endcase
    end

    // Even address takes the low byte
    assign nvram_port = '{
        addr:          addr,
        restore_data:  addr[0] ? restore_word.bytes.hi : restore_word.bytes.lo,
        restore_write: restore_write
    };

    assign nvram_hps_din = backup_word.word;

endmodule

// ==== hw/slave_worm_loader.sv ====
module slave_worm_loader (
    input  logic                  clk_sys,
    input  logic                  cditop_reset,
    input  cdi_host_pkg::ioctl_s  ioctl,
    output cdi_mem_pkg::worm_wr_s worm_wr
);
    import cdi_host_pkg::*;

    logic                   strobe;
    logic                   strobe_q;
    logic                   wr_q;
    logic [worm_addr_w-1:0] addr_q;
    logic [7:0]             data_q;
    logic [7:0]             high_byte;

    assign strobe = ioctl.wr && (index_sel(ioctl.index) == slave_worm);

    // Write enable covers the strobe cycle and the one after it
    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            strobe_q <= 1'b0;
            wr_q     <= 1'b0;
        end else begin
            strobe_q <= strobe;
            wr_q     <= strobe || strobe_q;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (strobe) begin
            // Low byte goes out first
            addr_q    <= ioctl.addr[worm_addr_w-1:0];
            data_q    <= ioctl.dout[7:0];
            high_byte <= ioctl.dout[15:8];
        end else begin
            // then the stored high byte at the odd address
            data_q    <= high_byte;
            addr_q[0] <= 1'b1;
        end
    end

    assign worm_wr = '{addr: addr_q, data: data_q, wr: wr_q};

endmodule

// ==== testbench/cdi_host_glue_chk.sv ====
module cdi_host_glue_chk (
    input logic clk_sys,
    input logic cditop_reset,
    input logic busy,
    input logic rd,
    input logic wr,
    input logic hps_rd,
    input logic hps_wr,
    input logic restore_write,
    input logic in_idle
);

    int fail_count = 0;

    // SDRAM controller takes nothing while busy
    busy_quiet: assert property (@(posedge clk_sys) (cditop_reset && busy) |-> !(rd || wr))
        else begin
            fail_count++;
            $error("SDRAM request issued while busy");
        end

    // Only one block-buffer direction at a time
    one_direction: assert property (@(posedge clk_sys) disable iff (cditop_reset)
        !(hps_rd && hps_wr))
        else begin
            fail_count++;
            $error("Block buffer read and write requested together");
        end

    restore_busy: assert property (@(posedge clk_sys) disable iff (cditop_reset)
        restore_write |-> !in_idle)
        else begin
            fail_count++;
            $error("NvRAM restore write while sequencer idle");
        end

endmodule

bind boot_sdram_arbiter cdi_host_glue_chk u_arb_chk (
    .clk_sys       (clk_sys),
    .cditop_reset  (cditop_reset),
    .busy          (sdram_busy),
    .rd            (sdram_req.rd),
    .wr            (sdram_req.wr),
    .hps_rd        (1'b0),
    .hps_wr        (1'b0),
    .restore_write (1'b0),
    .in_idle       (1'b0)
);

bind nvram_sync_fsm cdi_host_glue_chk u_fsm_chk (
    .clk_sys       (clk_sys),
    .cditop_reset  (cditop_reset),
    .busy          (1'b0),
    .rd            (1'b0),
    .wr            (1'b0),
    .hps_rd        (nvram_hps_rd),
    .hps_wr        (nvram_hps_wr),
    .restore_write (restore_write),
    .in_idle       (state == idle)
);

// ==== testbench/cdi_host_glue_golden.txt ====
# Columns (hex): type index addr data exp0 exp1
# type 1 ROM write and 4 overflow pair: exp0 SDRAM address, exp1 SDRAM data
# type 2 WORM word: exp0 low byte address, exp1 high byte address
# type 3 restore word: exp0 low byte, exp1 high byte
1 0000 0000124 1234 0400124 3412
1 0080 0000246 abcd 0480246 cdab
1 0000 007fffe 00ff 047fffe ff00
1 0080 01a0010 5aa5 04a0010 a55a
1 0000 0000135 0102 0400134 0201
4 0000 0003000 c3e1 0403000 e1c3
2 0040 0000100 beef 0100 0101
2 0040 0001ffe 1357 1ffe 1fff
2 0040 0000abc 2468 0abc 0abd
3 0000 0000000 a1b2 b2 a1
3 0000 0000000 c3d4 d4 c3
3 0000 0000000 0f10 10 0f
3 0000 0000000 7e81 81 7e

// ==== testbench/tb_cdi_host_glue.sv ====
module tb_cdi_host_glue;
    import cdi_host_pkg::*;
    import cdi_mem_pkg::*;

    localparam int wait_limit = 200;

    logic        clk_sys;
    logic        cditop_reset;
    ioctl_s      ioctl;
    sdram_req_s  core_req;
    logic        sdram_busy;
    blk_buf_s    nvram_blk;
    logic        nvram_mount;
    logic        osd_status;
    logic        nvram_cpu_changed;
    logic [7:0]  nvram_backup_data;
    sdram_req_s  sdram_req;
    worm_wr_s    worm_wr;
    nvram_port_s nvram_port;
    logic        nvram_hps_rd;
    logic        nvram_hps_wr;
    host_word_t  nvram_hps_din;
    logic        nvram_allow_cpu_access;
    logic        backup_pending;
    logic        download_overflow;

    int          errors, timeouts, seed, busy_left, cnt, n_rec, n_words, fd, code;
    int          wr_count, refresh_after, allow_violations, asserts;
    logic        hold_busy, take, restore_active;
    sdram_req_s  last_wr;
    logic [63:0] rnd;
    logic [7:0]  nv_mem [0:8191];
    logic [12:0] nv_addr_q;
    logic [20:0] worm_q[$];
    logic [20:0] nv_q[$];
    logic [31:0] r_type [0:31];
    logic [31:0] r_index [0:31];
    logic [31:0] r_addr [0:31];
    logic [31:0] r_data [0:31];
    logic [31:0] r_exp0 [0:31];
    logic [31:0] r_exp1 [0:31];
    logic [31:0] f0, f1, f2, f3, f4, f5;
    logic [8*128-1:0] line;

    initial clk_sys = 1'b0;
    always #5 clk_sys = ~clk_sys;

    cdi_host_glue uut (
        .clk_sys(clk_sys), .cditop_reset(cditop_reset), .ioctl(ioctl), .core_req(core_req),
        .sdram_busy(sdram_busy), .sdram_req(sdram_req), .download_overflow(download_overflow),
        .worm_wr(worm_wr), .nvram_blk(nvram_blk), .nvram_mount(nvram_mount),
        .osd_status(osd_status), .nvram_cpu_changed(nvram_cpu_changed),
        .nvram_backup_data(nvram_backup_data), .nvram_port(nvram_port),
        .nvram_hps_rd(nvram_hps_rd), .nvram_hps_wr(nvram_hps_wr),
        .nvram_hps_din(nvram_hps_din), .nvram_allow_cpu_access(nvram_allow_cpu_access),
        .backup_pending(backup_pending)
    );

    // ==================================================================
    // SDRAM, NvRAM and WORM models sampled mid-cycle
    // ==================================================================

    always @(negedge clk_sys) begin
        take = !sdram_busy && (sdram_req.rd || sdram_req.wr);
        if (!sdram_busy && sdram_req.wr) begin
            wr_count++;
            last_wr       = sdram_req;
            refresh_after = 0;
        end else if (!sdram_busy && sdram_req.rd) begin
            refresh_after++;
        end
        nv_addr_q = nvram_port.addr;
        if (nvram_port.restore_write) begin
            nv_mem[nvram_port.addr] = nvram_port.restore_data;
            nv_q.push_back({nvram_port.addr, nvram_port.restore_data});
        end
        if (restore_active && nvram_allow_cpu_access) allow_violations++;
        if (worm_wr.wr) worm_q.push_back({worm_wr.addr, worm_wr.data});
    end

    // Busy holds 1 to 4 cycles after an accepted request
    always @(posedge clk_sys) begin
        #1;
        nvram_backup_data = nv_mem[nv_addr_q];
        if (hold_busy) begin
            sdram_busy = 1'b1;
        end else if (sdram_busy) begin
            if (busy_left <= 1) sdram_busy = 1'b0;
            else busy_left--;
        end else if (take) begin
            sdram_busy = 1'b1;
            busy_left  = 1 + ($random(seed) & 3);
        end
    end

    task automatic step(input int n);
        repeat (n) @(posedge clk_sys);
        #1;
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got=%h expected=%h", $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("ERROR: timed out at %0t waiting for %s", $time, what);
    endtask

    task automatic strobe_rom(input int k);
        ioctl.index = r_index[k][15:0];
        ioctl.addr  = r_addr[k][24:0];
        ioctl.dout  = r_data[k][15:0];
        ioctl.wr    = 1'b1;
        step(1);
        ioctl.wr = 1'b0;
    endtask

    // Download is over once a refresh follows the write
    task automatic finish_rom(input int k);
        cnt = 0;
        while (!(wr_count >= 1 && refresh_after >= 1) && cnt < wait_limit) begin
            step(1);
            cnt++;
        end
        if (cnt >= wait_limit) report_timeout("SDRAM download write");
        check_value("write count", wr_count, 1);
        check_value("sdram_req.addr", last_wr.addr, r_exp0[k]);
        check_value("sdram_req.data", last_wr.data, r_exp1[k]);
        check_value("sdram_req.word", last_wr.word, 1);
        check_value("sdram_req.burst", last_wr.burst, 0);
    endtask

    task automatic force_overflow(input int k);
        ioctl.download = 1'b0;
        step(2);
        ioctl.download = 1'b1;
        step(2);
        check_value("download_overflow", download_overflow, 0);
        @(negedge clk_sys);
        hold_busy = 1'b1;
        step(2);
        strobe_rom(k);
        step(2);
        strobe_rom(k);
        @(negedge clk_sys);
        check_value("download_overflow", download_overflow, 1);
        hold_busy = 1'b0;
        step(1);
        wr_count = 0;
        finish_rom(k);
        ioctl.download = 1'b0;
        step(2);
        ioctl.download = 1'b1;
        step(2);
        check_value("download_overflow", download_overflow, 0);
    endtask

    task automatic load_worm_word(input int k);
        worm_q.delete();
        ioctl.index = r_index[k][15:0];
        ioctl.addr  = r_addr[k][24:0];
        ioctl.dout  = r_data[k][15:0];
        ioctl.wr    = 1'b1;
        step(1);
        ioctl.wr = 1'b0;
        cnt = 0;
        while (worm_q.size() < 2 && cnt < wait_limit) begin
            step(1);
            cnt++;
        end
        step(2);
        if (worm_q.size() < 2) begin
            report_timeout("two WORM writes");
        end else begin
            check_value("worm write count", worm_q.size(), 2);
            check_value("worm_wr.addr", worm_q[0][20:8], r_exp0[k]);
            check_value("worm_wr.data", worm_q[0][7:0], r_data[k][7:0]);
            check_value("worm_wr.addr", worm_q[1][20:8], r_exp1[k]);
            check_value("worm_wr.data", worm_q[1][7:0], r_data[k][15:8]);
        end
    endtask

    task automatic restore_image();
        int k;
        int w;
        nv_q.delete();
        nvram_mount = 1'b1;
        step(1);
        nvram_mount = 1'b0;
        cnt = 0;
        while (!nvram_hps_rd && cnt < wait_limit) begin
            @(negedge clk_sys);
            cnt++;
        end
        if (cnt >= wait_limit) report_timeout("nvram_hps_rd");
        step(1);
        restore_active = 1'b1;
        nvram_blk.ack  = 1'b1;
        step(1);
        // Read request drops once the host acknowledges
        check_value("nvram_hps_rd", nvram_hps_rd, 0);
        w = 0;
        for (k = 0; k < n_rec; k++) begin
            if (r_type[k] == 3) begin
                nvram_blk.buff_dout = r_data[k][15:0];
                nvram_blk.buff_wr   = 1'b1;
                step(1);
                nvram_blk.buff_wr = 1'b0;
                step(3);
            end
        end
        nvram_blk.ack  = 1'b0;
        restore_active = 1'b0;
        cnt = 0;
        while (!nvram_allow_cpu_access && cnt < wait_limit) begin
            @(negedge clk_sys);
            cnt++;
        end
        if (cnt >= wait_limit) report_timeout("CPU access after restore");
        check_value("allow_cpu_access low cycles", allow_violations, 0);
        check_value("restore byte count", nv_q.size(), 2 * n_words);
        for (k = 0; k < n_rec; k++) begin
            if (r_type[k] == 3 && nv_q.size() >= 2 * w + 2) begin
                check_value("nvram_port.addr", nv_q[2 * w][20:8], 2 * w);
                check_value("nvram_port.restore_data", nv_q[2 * w][7:0], r_exp0[k]);
                check_value("nvram_port.addr", nv_q[2 * w + 1][20:8], 2 * w + 1);
                check_value("nvram_port.restore_data", nv_q[2 * w + 1][7:0], r_exp1[k]);
                w++;
            end
        end
    endtask

    task automatic backup_image();
        int k;
        step(1);
        nvram_cpu_changed = 1'b1;
        step(1);
        nvram_cpu_changed = 1'b0;
        @(negedge clk_sys);
        check_value("backup_pending", backup_pending, 1);
        step(1);
        osd_status = 1'b1;
        cnt = 0;
        while (!nvram_hps_wr && cnt < wait_limit) begin
            @(negedge clk_sys);
            cnt++;
        end
        if (cnt >= wait_limit) report_timeout("nvram_hps_wr");
        check_value("backup_pending", backup_pending, 0);
        step(1);
        nvram_blk.ack = 1'b1;
        for (k = 0; k < n_words; k++) begin
            step(5);
            @(negedge clk_sys);
            check_value("nvram_hps_din", nvram_hps_din, {nv_mem[2 * k + 1], nv_mem[2 * k]});
            step(1);
            if (k < n_words - 1) nvram_blk.buff_addr = nvram_blk.buff_addr + 1'b1;
            else nvram_blk.ack = 1'b0;
        end
        cnt = 0;
        while (!nvram_allow_cpu_access && cnt < wait_limit) begin
            @(negedge clk_sys);
            cnt++;
        end
        if (cnt >= wait_limit) report_timeout("CPU access after backup");
        check_value("nvram_hps_wr", nvram_hps_wr, 0);
        check_value("backup_pending", backup_pending, 0);
        step(1);
        osd_status = 1'b0;
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================

    initial begin
        int i;
        errors            = 0;
        timeouts          = 0;
        seed              = 32'h573;
        busy_left         = 0;
        n_rec             = 0;
        n_words           = 0;
        wr_count          = 0;
        refresh_after     = 0;
        allow_violations  = 0;
        hold_busy         = 1'b0;
        take              = 1'b0;
        restore_active    = 1'b0;
        cditop_reset      = 1'b1;
        ioctl             = '0;
        core_req          = '0;
        sdram_busy        = 1'b0;
        nvram_blk         = '0;
        nvram_mount       = 1'b0;
        osd_status        = 1'b0;
        nvram_cpu_changed = 1'b0;
        nvram_backup_data = 8'h00;
        for (i = 0; i < 8192; i++) nv_mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5c;

        fd = $fopen("testbench/cdi_host_glue_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("ERROR: the golden data file could not be opened");
        end else begin
            while (!$feof(fd) && n_rec < 32) begin
                code = $fscanf(fd, "%h %h %h %h %h %h\n", f0, f1, f2, f3, f4, f5);
                if (code == 6) begin
                    r_type[n_rec]  = f0;
                    r_index[n_rec] = f1;
                    r_addr[n_rec]  = f2;
                    r_data[n_rec]  = f3;
                    r_exp0[n_rec]  = f4;
                    r_exp1[n_rec]  = f5;
                    if (f0 == 3) n_words++;
                    n_rec++;
                end else begin
                    code = $fgets(line, fd);
                end
            end
            $fclose(fd);
        end
        if (n_rec == 0) begin
            errors++;
            $display("ERROR: no stimulus records were read");
        end
        step(3);
        cditop_reset = 1'b0;
        step(2);

        // Downloads while the core is held in reset
        cditop_reset   = 1'b1;
        ioctl.download = 1'b1;
        cnt = 0;
        while (!(!sdram_busy && sdram_req.rd) && cnt < wait_limit) begin
            @(negedge clk_sys);
            cnt++;
        end
        if (cnt >= wait_limit) report_timeout("refresh request in reset");
        check_value("sdram_req.refresh", sdram_req.refresh, 1);
        check_value("sdram_req.wr", sdram_req.wr, 0);
        step(1);
        for (i = 0; i < n_rec; i++) begin
            if (r_type[i] == 1) begin
                wr_count = 0;
                strobe_rom(i);
                finish_rom(i);
            end else if (r_type[i] == 4) begin
                force_overflow(i);
            end
        end
        ioctl.download = 1'b0;
        step(2);
        cditop_reset = 1'b0;

        // Core owns SDRAM
        for (i = 0; i < 4; i++) begin
            rnd      = {$random(seed), $random(seed)};
            core_req = rnd[$bits(sdram_req_s)-1:0];
            @(negedge clk_sys);
            check_value("sdram_req", sdram_req, core_req);
            step(1);
        end
        core_req = '0;
        step(6);

        for (i = 0; i < n_rec; i++) begin
            if (r_type[i] == 2) load_worm_word(i);
        end
        restore_image();
        backup_image();

        step(2);
        asserts = uut.u_sdram_arbiter.u_arb_chk.fail_count
                + uut.u_nvram_sync.u_fsm_chk.fail_count;
        $display("Checks done: %0d mismatches, %0d timeouts, %0d assertion failures",
                 errors, timeouts, asserts);
        if (errors == 0 && timeouts == 0 && asserts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
